/* hdl/mult_macros.svh */
`ifndef MULT_MACROS_SVH
`define MULT_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////////////////////

// full operand and result word
`define MULT_WIDTH 32
// half-word lane, also the short multiplier operand width
`define MULT_HALF 16
// byte lane for the 8-bit dot product
`define MULT_BYTE 8

////////////////////////////////////////////////////////////////////////////
// shift constants
////////////////////////////////////////////////////////////////////////////

// width of the right shift amount
`define MULT_IMM_WIDTH 5
// realignment shift used in upper-half steps 0 and 2
`define MULT_MULH_SHIFT 16

`endif

/* hdl/mult_pkg.sv */
`include "mult_macros.svh"

package mult_pkg;

  // operator encoding as seen on operator_i
  typedef enum logic [2:0] {
    MUL_MAC32 = 3'd0,
    MUL_MSU32 = 3'd1,
    MUL_I     = 3'd2,
    MUL_IR    = 3'd3,
    MUL_DOT8  = 3'd4,
    MUL_DOT16 = 3'd5,
    MUL_H     = 3'd6,
    // nibble dot product is not implemented and reads as zero
    MUL_DOT4  = 3'd7
  } mult_op_e;

  // upper-half multiply sequencer states
  typedef enum logic [2:0] {
    IDLE   = 3'd0,
    STEP0  = 3'd1,
    STEP1  = 3'd2,
    STEP2  = 3'd3,
    FINISH = 3'd4
  } mulh_state_e;

  // one dot operand word
  // read as four byte lanes or as two half-word lanes
  typedef union packed {
    logic [`MULT_WIDTH/`MULT_BYTE-1:0][`MULT_BYTE-1:0] lane8;
    logic [`MULT_WIDTH/`MULT_HALF-1:0][`MULT_HALF-1:0] lane16;
  } dot_word_u;

endpackage

/* hdl/mulh_sequencer.sv */
`include "mult_macros.svh"

module mulh_sequencer import mult_pkg::*; (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       enable_i,
  input  mult_op_e                   operator_i,
  input  logic [1:0]                 short_signed_i,
  input  logic                       mac_carry_i,
  input  logic                       ex_ready_i,
  output logic                       mulh_active_o,
  output logic [`MULT_IMM_WIDTH-1:0] mulh_imm_o,
  output logic [1:0]                 mulh_subword_o,
  output logic [1:0]                 mulh_signed_o,
  output logic                       mulh_shift_arith_o,
  output logic                       mulh_carry_o,
  output logic                       multicycle_o,
  output logic                       ready_o
);

  mulh_state_e state_q;
  mulh_state_e state_d;
  logic        carry_q;
  logic        mulh_save;
  logic        mulh_clear_carry;

  ////////////////////////////////////////////////////////////////////////////
  // step control
  ////////////////////////////////////////////////////////////////////////////

  // subword bit 0 picks the A half, bit 1 the B half
  // signed bit 0 governs A, bit 1 governs B
  always_comb begin
    state_d            = state_q;
    mulh_active_o      = 1'b1;
    mulh_imm_o         = '0;
    mulh_subword_o     = 2'b00;
    mulh_signed_o      = 2'b00;
    mulh_shift_arith_o = 1'b0;
    mulh_save          = 1'b0;
    mulh_clear_carry   = 1'b0;
    multicycle_o       = 1'b0;
    ready_o            = 1'b0;
    case (state_q)
      IDLE: begin
        // short datapath is free for single-cycle ops
        mulh_active_o = 1'b0;
        ready_o       = 1'b1;
        if (enable_i && (operator_i == MUL_H)) begin
          // busy from the start cycle on
          ready_o = 1'b0;
          state_d = STEP0;
        end
      end
      STEP0: begin
        // low times low, unsigned and never wider than 32 bits
        multicycle_o = 1'b1;
        mulh_imm_o   = `MULT_IMM_WIDTH'(`MULT_MULH_SHIFT);
        state_d      = STEP1;
      end
      STEP1: begin
        // low A times high B, signed only when B is
        multicycle_o       = 1'b1;
        mulh_signed_o      = {short_signed_i[1], 1'b0};
        mulh_subword_o     = 2'b10;
        mulh_shift_arith_o = 1'b1;
        // 33-bit partial sum, bit 32 kept as sign extension
        mulh_save          = 1'b1;
        state_d            = STEP2;
      end
      STEP2: begin
        // high A times low B, signed only when A is
        multicycle_o       = 1'b1;
        mulh_signed_o      = {1'b0, short_signed_i[0]};
        mulh_subword_o     = 2'b01;
        mulh_imm_o         = `MULT_IMM_WIDTH'(`MULT_MULH_SHIFT);
        mulh_shift_arith_o = 1'b1;
        // upper bits are shifted back in, so the carry is dropped
        mulh_save          = 1'b1;
        mulh_clear_carry   = 1'b1;
        state_d            = FINISH;
      end
      FINISH: begin
        // high times high closes the sum, result valid here
        mulh_signed_o  = short_signed_i;
        mulh_subword_o = 2'b11;
        ready_o        = 1'b1;
        if (ex_ready_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // state and carry registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      carry_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (mulh_save) begin
        carry_q <= ~mulh_clear_carry & mac_carry_i;
      end else if (ex_ready_i) begin
        // next instruction starts from a clean carry
        carry_q <= 1'b0;
      end
    end
  end

  assign mulh_carry_o = carry_q;

  // busy and ready are mutually exclusive
  assert property (@(posedge clk) disable iff (!rst_n) !(multicycle_o && ready_o));

  // state register only holds the five defined encodings
  assert property (@(posedge clk) disable iff (!rst_n)
    state_q inside {IDLE, STEP0, STEP1, STEP2, FINISH});

endmodule

/* hdl/short_mac.sv */
`include "mult_macros.svh"

module short_mac import mult_pkg::*; (
  input  mult_op_e                   operator_i,
  input  logic [`MULT_WIDTH-1:0]     op_a_i,
  input  logic [`MULT_WIDTH-1:0]     op_b_i,
  input  logic [`MULT_WIDTH-1:0]     op_c_i,
  input  logic [`MULT_IMM_WIDTH-1:0] imm_i,
  input  logic                       short_subword_i,
  input  logic [1:0]                 short_signed_i,
  input  logic                       mulh_active_i,
  input  logic [`MULT_IMM_WIDTH-1:0] mulh_imm_i,
  input  logic [1:0]                 mulh_subword_i,
  input  logic [1:0]                 mulh_signed_i,
  input  logic                       mulh_shift_arith_i,
  input  logic                       mulh_carry_i,
  output logic [`MULT_WIDTH-1:0]     short_result_o,
  output logic                       mac_carry_o
);

  logic [`MULT_HALF:0]         short_op_a;
  logic [`MULT_HALF:0]         short_op_b;
  logic [`MULT_WIDTH:0]        short_op_c;
  logic [`MULT_WIDTH+1:0]      short_mul;
  logic [`MULT_WIDTH+1:0]      short_sum;
  logic [`MULT_WIDTH+1:0]      short_shifted;
  logic [`MULT_WIDTH-1:0]      round_tmp;
  logic [`MULT_WIDTH-1:0]      short_round;
  logic                        round_en;
  logic [`MULT_IMM_WIDTH-1:0]  short_imm;
  logic [1:0]                  short_subword;
  logic [1:0]                  short_signed;
  logic                        short_shift_arith;
  logic                        sum_msb1;
  logic                        sum_msb0;

  // sequencer takes over the controls during upper-half steps
  assign short_imm         = mulh_active_i ? mulh_imm_i : imm_i;
  assign short_subword     = mulh_active_i ? mulh_subword_i : {2{short_subword_i}};
  assign short_signed      = mulh_active_i ? mulh_signed_i : short_signed_i;
  assign short_shift_arith = mulh_active_i ? mulh_shift_arith_i : short_signed_i[0];

  // rounding adds half an lsb of the shifted result
  assign round_en    = (operator_i == MUL_IR);
  assign round_tmp   = `MULT_WIDTH'(1) << imm_i;
  assign short_round = round_en ? {1'b0, round_tmp[`MULT_WIDTH-1:1]} : '0;

  // half-word select with a 17th bit for the sign
  assign short_op_a[`MULT_HALF-1:0] = short_subword[0] ? op_a_i[`MULT_WIDTH-1:`MULT_HALF]
                                                       : op_a_i[`MULT_HALF-1:0];
  assign short_op_b[`MULT_HALF-1:0] = short_subword[1] ? op_b_i[`MULT_WIDTH-1:`MULT_HALF]
                                                       : op_b_i[`MULT_HALF-1:0];
  assign short_op_a[`MULT_HALF] = short_signed[0] & short_op_a[`MULT_HALF-1];
  assign short_op_b[`MULT_HALF] = short_signed[1] & short_op_b[`MULT_HALF-1];

  // accumulator widens by the saved carry in upper-half steps
  assign short_op_c = mulh_active_i ? {mulh_carry_i, op_c_i}
                                    : {op_c_i[`MULT_WIDTH-1], op_c_i};

  ////////////////////////////////////////////////////////////////////////////
  // multiply, accumulate, shift
  ////////////////////////////////////////////////////////////////////////////

  assign short_mul = $signed(short_op_a) * $signed(short_op_b);
  assign short_sum = $signed(short_op_c) + $signed(short_mul) + $signed(short_round);

  // upper-half steps keep two real top bits, plain ops replicate bit 31
  assign sum_msb1 = mulh_active_i ? short_sum[`MULT_WIDTH+1] : short_sum[`MULT_WIDTH-1];
  assign sum_msb0 = mulh_active_i ? short_sum[`MULT_WIDTH] : short_sum[`MULT_WIDTH-1];

  assign short_shifted = $signed({short_shift_arith & sum_msb1,
                                  short_shift_arith & sum_msb0,
                                  short_sum[`MULT_WIDTH-1:0]}) >>> short_imm;

  assign short_result_o = short_shifted[`MULT_WIDTH-1:0];
  // partial-sum sign kept by the sequencer
  assign mac_carry_o    = short_sum[`MULT_WIDTH];

  // MUL_H is held through the sequence, so IR rounding never meets it
  always_comb begin
    assert final (!(mulh_active_i && round_en));
  end

endmodule

/* hdl/dot_mult.sv */
`include "mult_macros.svh"

module dot_mult import mult_pkg::*; (
  input  logic [1:0]             dot_signed_i,
  input  dot_word_u              dot_op_a_i,
  input  dot_word_u              dot_op_b_i,
  input  dot_word_u              dot_op_c_i,
  output logic [`MULT_WIDTH-1:0] dot8_result_o,
  output logic [`MULT_WIDTH-1:0] dot16_result_o
);

  localparam int N8  = `MULT_WIDTH / `MULT_BYTE;
  localparam int N16 = `MULT_WIDTH / `MULT_HALF;

  // lanes carry one extra bit for sign extension
  logic [N8-1:0][`MULT_BYTE:0]        char_a;
  logic [N8-1:0][`MULT_BYTE:0]        char_b;
  logic [N8-1:0][2*`MULT_BYTE+1:0]    char_mul;
  logic [N16-1:0][`MULT_HALF:0]       half_a;
  logic [N16-1:0][`MULT_HALF:0]       half_b;
  logic [N16-1:0][2*`MULT_HALF+1:0]   half_mul;
  logic [`MULT_WIDTH-1:0]             char_sum;
  logic [`MULT_WIDTH-1:0]             half_sum;

  ////////////////////////////////////////////////////////////////////////////
  // 8-bit lanes
  ////////////////////////////////////////////////////////////////////////////

  // bit 1 of dot_signed_i governs A, bit 0 governs B
  always_comb begin
    char_sum = dot_op_c_i;
    for (int i = 0; i < N8; i++) begin
      char_a[i]   = {dot_signed_i[1] & dot_op_a_i.lane8[i][`MULT_BYTE-1],
                     dot_op_a_i.lane8[i]};
      char_b[i]   = {dot_signed_i[0] & dot_op_b_i.lane8[i][`MULT_BYTE-1],
                     dot_op_b_i.lane8[i]};
      char_mul[i] = $signed(char_a[i]) * $signed(char_b[i]);
      // product sign-extends into the 32-bit sum
      char_sum    = $signed(char_sum) + $signed(char_mul[i]);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // 16-bit lanes
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    half_sum = dot_op_c_i;
    for (int i = 0; i < N16; i++) begin
      half_a[i]   = {dot_signed_i[1] & dot_op_a_i.lane16[i][`MULT_HALF-1],
                     dot_op_a_i.lane16[i]};
      half_b[i]   = {dot_signed_i[0] & dot_op_b_i.lane16[i][`MULT_HALF-1],
                     dot_op_b_i.lane16[i]};
      half_mul[i] = $signed(half_a[i]) * $signed(half_b[i]);
      // only the low word of each product matters modulo 2^32
      half_sum    = half_sum + half_mul[i][`MULT_WIDTH-1:0];
    end
  end

  assign dot8_result_o  = char_sum;
  assign dot16_result_o = half_sum;

endmodule

/* hdl/mult_unit.sv */
`include "mult_macros.svh"

module mult_unit import mult_pkg::*; (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       enable_i,
  input  mult_op_e                   operator_i,
  input  logic [`MULT_WIDTH-1:0]     op_a_i,
  input  logic [`MULT_WIDTH-1:0]     op_b_i,
  input  logic [`MULT_WIDTH-1:0]     op_c_i,
  input  logic [`MULT_IMM_WIDTH-1:0] imm_i,
  input  logic                       short_subword_i,
  input  logic [1:0]                 short_signed_i,
  input  logic [1:0]                 dot_signed_i,
  input  dot_word_u                  dot_op_a_i,
  input  dot_word_u                  dot_op_b_i,
  input  dot_word_u                  dot_op_c_i,
  input  logic                       ex_ready_i,
  output logic [`MULT_WIDTH-1:0]     result_o,
  output logic                       multicycle_o,
  output logic                       ready_o
);

  logic                       mulh_active;
  logic [`MULT_IMM_WIDTH-1:0] mulh_imm;
  logic [1:0]                 mulh_subword;
  logic [1:0]                 mulh_signed;
  logic                       mulh_shift_arith;
  logic                       mulh_carry;
  logic                       mac_carry;
  logic [`MULT_WIDTH-1:0]     mulh_acc_q;
  logic [`MULT_WIDTH-1:0]     short_op_c;
  logic [`MULT_WIDTH-1:0]     short_result;
  logic [`MULT_WIDTH-1:0]     dot8_result;
  logic [`MULT_WIDTH-1:0]     dot16_result;
  logic                       int_is_msu;
  logic [`MULT_WIDTH-1:0]     int_op_a_msu;
  logic [`MULT_WIDTH-1:0]     int_op_b_msu;
  logic [`MULT_WIDTH-1:0]     int_result;

  ////////////////////////////////////////////////////////////////////////////
  // 32-bit MAC and MSU
  ////////////////////////////////////////////////////////////////////////////

  // c - a*b rewritten as c + (~a)*b + b
  assign int_is_msu   = (operator_i == MUL_MSU32);
  assign int_op_a_msu = op_a_i ^ {`MULT_WIDTH{int_is_msu}};
  assign int_op_b_msu = op_b_i & {`MULT_WIDTH{int_is_msu}};
  assign int_result   = op_c_i + int_op_b_msu + int_op_a_msu * op_b_i;

  ////////////////////////////////////////////////////////////////////////////
  // upper-half multiply
  ////////////////////////////////////////////////////////////////////////////

  mulh_sequencer mulh_sequencer_inst (
    .clk                (clk),
    .rst_n              (rst_n),
    .enable_i           (enable_i),
    .operator_i         (operator_i),
    .short_signed_i     (short_signed_i),
    .mac_carry_i        (mac_carry),
    .ex_ready_i         (ex_ready_i),
    .mulh_active_o      (mulh_active),
    .mulh_imm_o         (mulh_imm),
    .mulh_subword_o     (mulh_subword),
    .mulh_signed_o      (mulh_signed),
    .mulh_shift_arith_o (mulh_shift_arith),
    .mulh_carry_o       (mulh_carry),
    .multicycle_o       (multicycle_o),
    .ready_o            (ready_o)
  );

  // partial sum between steps
  // zero while idle so step 0 starts from an empty accumulator
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mulh_acc_q <= '0;
    end else if (!mulh_active) begin
      mulh_acc_q <= '0;
    end else if (multicycle_o) begin
      mulh_acc_q <= short_result;
    end
  end

  // steps feed back the partial sum, plain short ops use op_c
  assign short_op_c = mulh_active ? mulh_acc_q : op_c_i;

  short_mac short_mac_inst (
    .operator_i         (operator_i),
    .op_a_i             (op_a_i),
    .op_b_i             (op_b_i),
    .op_c_i             (short_op_c),
    .imm_i              (imm_i),
    .short_subword_i    (short_subword_i),
    .short_signed_i     (short_signed_i),
    .mulh_active_i      (mulh_active),
    .mulh_imm_i         (mulh_imm),
    .mulh_subword_i     (mulh_subword),
    .mulh_signed_i      (mulh_signed),
    .mulh_shift_arith_i (mulh_shift_arith),
    .mulh_carry_i       (mulh_carry),
    .short_result_o     (short_result),
    .mac_carry_o        (mac_carry)
  );

  // dot products
  dot_mult dot_mult_inst (
    .dot_signed_i   (dot_signed_i),
    .dot_op_a_i     (dot_op_a_i),
    .dot_op_b_i     (dot_op_b_i),
    .dot_op_c_i     (dot_op_c_i),
    .dot8_result_o  (dot8_result),
    .dot16_result_o (dot16_result)
  );

  ////////////////////////////////////////////////////////////////////////////
  // result select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    result_o = '0;
    case (operator_i)
      MUL_MAC32, MUL_MSU32: result_o = int_result;
      MUL_I, MUL_IR, MUL_H: result_o = short_result;
      MUL_DOT8:             result_o = dot8_result;
      MUL_DOT16:            result_o = dot16_result;
      // nibble dot product reads as zero
      default:              result_o = '0;
    endcase
  end

  // FINISH under back-pressure keeps the upper half steady
  assert property (@(posedge clk) disable iff (!rst_n)
    (mulh_active && ready_o && !ex_ready_i) |=> ($stable(result_o) && ready_o));

endmodule

/* verification/tb_clock_gen.sv */
module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // 20 ns period
  localparam int HALF_PERIOD_NS = 10;
  localparam int RESET_CYCLES   = 10;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  // reset held low over the first ten rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

/* verification/mult_unit_tb.sv */
`include "mult_macros.svh"

module mult_unit_tb import mult_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  // repetitions per directed test
  localparam int N_MAC       = 16;
  localparam int N_SHORT_REP = 2;
  localparam int N_MULH_REP  = 2;
  localparam int N_BP_REP    = 2;
  localparam int N_DOT_REP   = 2;
  // one entry per checked transaction
  localparam int NUM_TESTS = 1 + 2 * N_MAC + 16 * N_SHORT_REP + 3 * N_MULH_REP
                             + 2 * N_BP_REP + 8 * N_DOT_REP + 1;
  localparam int WATCHDOG_CYCLES = 10 + NUM_TESTS * 40;

  logic                       clk;
  logic                       rst_n;
  logic                       enable;
  mult_op_e                   operator;
  logic [`MULT_WIDTH-1:0]     op_a;
  logic [`MULT_WIDTH-1:0]     op_b;
  logic [`MULT_WIDTH-1:0]     op_c;
  logic [`MULT_IMM_WIDTH-1:0] imm;
  logic                       short_subword;
  logic [1:0]                 short_signed;
  logic [1:0]                 dot_signed;
  dot_word_u                  dot_a;
  dot_word_u                  dot_b;
  dot_word_u                  dot_c;
  logic                       ex_ready;
  logic [`MULT_WIDTH-1:0]     result;
  logic                       multicycle;
  logic                       ready;

  tb_clock_gen tb_clock_gen_inst (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  mult_unit mult_unit_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .enable_i        (enable),
    .operator_i      (operator),
    .op_a_i          (op_a),
    .op_b_i          (op_b),
    .op_c_i          (op_c),
    .imm_i           (imm),
    .short_subword_i (short_subword),
    .short_signed_i  (short_signed),
    .dot_signed_i    (dot_signed),
    .dot_op_a_i      (dot_a),
    .dot_op_b_i      (dot_b),
    .dot_op_c_i      (dot_c),
    .ex_ready_i      (ex_ready),
    .result_o        (result),
    .multicycle_o    (multicycle),
    .ready_o         (ready)
  );

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic compare_word(string name, logic [`MULT_WIDTH-1:0] exp,
                              logic [`MULT_WIDTH-1:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, exp, act);
      $display("STATUS: FAIL");
      $fatal(1, "result mismatch");
    end
  endtask

  task automatic compare_flag(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
      $display("STATUS: FAIL");
      $fatal(1, "status flag mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // expected values
  ////////////////////////////////////////////////////////////////////////////

  // signed bit 0 extends A and picks the arithmetic shift, bit 1 extends B
  function automatic logic [31:0] expect_short(mult_op_e op, logic [31:0] a, logic [31:0] b,
                                               logic [31:0] c, logic [4:0] sh, logic sub,
                                               logic [1:0] sgn);
    logic [15:0] ha;
    logic [15:0] hb;
    logic [31:0] xa;
    logic [31:0] xb;
    logic [31:0] rnd;
    logic [31:0] word;
    ha   = sub ? a[31:16] : a[15:0];
    hb   = sub ? b[31:16] : b[15:0];
    xa   = sgn[0] ? {{16{ha[15]}}, ha} : {16'b0, ha};
    xb   = sgn[1] ? {{16{hb[15]}}, hb} : {16'b0, hb};
    // half an lsb of the shifted result, nothing for a zero shift
    rnd  = (op == MUL_IR && sh != 0) ? (32'd1 << (sh - 1)) : 32'd0;
    word = c + xa * xb + rnd;
    if (sgn[0]) begin
      return $signed(word) >>> sh;
    end else begin
      return word >> sh;
    end
  endfunction

  // upper word of the full 64-bit product
  function automatic logic [31:0] expect_mulh(logic [31:0] a, logic [31:0] b, logic [1:0] sgn);
    logic [63:0] a64;
    logic [63:0] b64;
    logic [63:0] prod;
    a64  = sgn[0] ? {{32{a[31]}}, a} : {32'b0, a};
    b64  = sgn[1] ? {{32{b[31]}}, b} : {32'b0, b};
    prod = a64 * b64;
    return prod[63:32];
  endfunction

  // dot signedness: bit 1 for A lanes, bit 0 for B lanes
  function automatic logic [31:0] expect_dot8(dot_word_u a, dot_word_u b, dot_word_u c,
                                              logic [1:0] sgn);
    logic [31:0] sum;
    logic [31:0] xa;
    logic [31:0] xb;
    sum = c;
    for (int i = 0; i < 4; i++) begin
      xa  = sgn[1] ? {{24{a.lane8[i][7]}}, a.lane8[i]} : {24'b0, a.lane8[i]};
      xb  = sgn[0] ? {{24{b.lane8[i][7]}}, b.lane8[i]} : {24'b0, b.lane8[i]};
      sum = sum + xa * xb;
    end
    return sum;
  endfunction

  function automatic logic [31:0] expect_dot16(dot_word_u a, dot_word_u b, dot_word_u c,
                                               logic [1:0] sgn);
    logic [31:0] sum;
    logic [31:0] xa;
    logic [31:0] xb;
    sum = c;
    for (int i = 0; i < 2; i++) begin
      xa  = sgn[1] ? {{16{a.lane16[i][15]}}, a.lane16[i]} : {16'b0, a.lane16[i]};
      xb  = sgn[0] ? {{16{b.lane16[i][15]}}, b.lane16[i]} : {16'b0, b.lane16[i]};
      sum = sum + xa * xb;
    end
    return sum;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    @(negedge clk);
    compare_flag("reset ready", 1'b1, ready);
    compare_flag("reset multicycle", 1'b0, multicycle);
  endtask

  task automatic test_mac();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    for (int i = 0; i < N_MAC; i++) begin
      a = $urandom();
      b = $urandom();
      c = $urandom();
      @(posedge clk);
      enable   <= 1'b1;
      operator <= MUL_MAC32;
      op_a     <= a;
      op_b     <= b;
      op_c     <= c;
      @(negedge clk);
      compare_word("mac32", c + a * b, result);
      compare_flag("mac32 ready", 1'b1, ready);
      @(posedge clk);
      operator <= MUL_MSU32;
      @(negedge clk);
      compare_word("msu32", c - a * b, result);
    end
  endtask

  task automatic test_short();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [4:0]  sh;
    mult_op_e    op;
    for (int k = 0; k < 2; k++) begin
      if (k == 0) begin
        op = MUL_I;
      end else begin
        op = MUL_IR;
      end
      for (int sub = 0; sub < 2; sub++) begin
        for (int sgn = 0; sgn < 4; sgn++) begin
          for (int r = 0; r < N_SHORT_REP; r++) begin
            a  = $urandom();
            b  = $urandom();
            c  = $urandom();
            sh = 5'($urandom_range(31, 0));
            @(posedge clk);
            enable        <= 1'b1;
            operator      <= op;
            op_a          <= a;
            op_b          <= b;
            op_c          <= c;
            imm           <= sh;
            short_subword <= sub[0];
            short_signed  <= sgn[1:0];
            @(negedge clk);
            compare_word($sformatf("%s sub%0d sgn%0d imm%0d", op.name(), sub, sgn, sh),
                         expect_short(op, a, b, c, sh, sub[0], sgn[1:0]), result);
          end
        end
      end
    end
  endtask

  // start one upper-half multiply and stop in FINISH
  task automatic run_mulh(string name, logic [31:0] a, logic [31:0] b, logic [1:0] sgn,
                          logic exr);
    int steps;
    @(posedge clk);
    enable       <= 1'b1;
    operator     <= MUL_H;
    op_a         <= a;
    op_b         <= b;
    op_c         <= $urandom();
    imm          <= 5'($urandom_range(31, 0));
    short_signed <= sgn;
    ex_ready     <= exr;
    // start cycle, ready drops before the first step
    @(negedge clk);
    compare_flag({name, " start ready"}, 1'b0, ready);
    steps = 0;
    @(negedge clk);
    while (!ready) begin
      compare_flag({name, " busy"}, 1'b1, multicycle);
      steps++;
      @(negedge clk);
    end
    compare_word({name, " step count"}, 32'd3, 32'(steps));
    compare_flag({name, " finish multicycle"}, 1'b0, multicycle);
    compare_word({name, " upper half"}, expect_mulh(a, b, sgn), result);
  endtask

  task automatic test_mulh();
    logic [1:0] sgn;
    for (int v = 0; v < 3; v++) begin
      // 11, 01 and 00
      sgn = (v == 0) ? 2'b11 : ((v == 1) ? 2'b01 : 2'b00);
      for (int r = 0; r < N_MULH_REP; r++) begin
        run_mulh($sformatf("mulh sgn%b", sgn), $urandom(), $urandom(), sgn, 1'b1);
        // leave FINISH with a quiet bus
        @(posedge clk);
        enable   <= 1'b0;
        operator <= MUL_MAC32;
        @(negedge clk);
        compare_flag("mulh back to idle", 1'b1, ready);
      end
    end
  endtask

  task automatic test_backpressure();
    logic [31:0] held;
    logic [31:0] ma;
    logic [31:0] mb;
    logic [1:0]  sgn;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    int          n;
    for (int r = 0; r < N_BP_REP; r++) begin
      ma   = $urandom();
      mb   = $urandom();
      sgn  = (r == 0) ? 2'b11 : 2'b00;
      run_mulh("backpressure mulh", ma, mb, sgn, 1'b0);
      held = expect_mulh(ma, mb, sgn);
      n    = $urandom_range(8, 2);
      repeat (n) begin
        @(negedge clk);
        compare_word("backpressure result", held, result);
        compare_flag("backpressure ready", 1'b1, ready);
      end
      @(posedge clk);
      ex_ready <= 1'b1;
      // this edge leaves FINISH, the next op goes in with it
      @(posedge clk);
      a = $urandom();
      b = $urandom();
      c = $urandom();
      operator <= MUL_MAC32;
      op_a     <= a;
      op_b     <= b;
      op_c     <= c;
      @(negedge clk);
      compare_word("mac32 after backpressure", c + a * b, result);
      compare_flag("ready after backpressure", 1'b1, ready);
    end
  endtask

  task automatic test_dot();
    dot_word_u da;
    dot_word_u db;
    dot_word_u dc;
    mult_op_e  op;
    for (int k = 0; k < 2; k++) begin
      if (k == 0) begin
        op = MUL_DOT8;
      end else begin
        op = MUL_DOT16;
      end
      for (int sgn = 0; sgn < 4; sgn++) begin
        for (int r = 0; r < N_DOT_REP; r++) begin
          // byte lanes filled one by one
          for (int i = 0; i < 4; i++) begin
            da.lane8[i] = 8'($urandom());
            db.lane8[i] = 8'($urandom());
          end
          dc = $urandom();
          @(posedge clk);
          enable     <= 1'b1;
          operator   <= op;
          dot_signed <= sgn[1:0];
          dot_a      <= da;
          dot_b      <= db;
          dot_c      <= dc;
          @(negedge clk);
          if (op == MUL_DOT8) begin
            compare_word($sformatf("dot8 sgn%0d", sgn), expect_dot8(da, db, dc, sgn[1:0]),
                         result);
          end else begin
            compare_word($sformatf("dot16 sgn%0d", sgn), expect_dot16(da, db, dc, sgn[1:0]),
                         result);
          end
        end
      end
    end
    // nibble dot product code reads as zero
    @(posedge clk);
    operator <= MUL_DOT4;
    @(negedge clk);
    compare_word("dot4 dropped", 32'd0, result);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // run control
  ////////////////////////////////////////////////////////////////////////////

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("STATUS: FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    void'($urandom(32'hb979));
    enable        = 1'b0;
    operator      = MUL_MAC32;
    op_a          = '0;
    op_b          = '0;
    op_c          = '0;
    imm           = '0;
    short_subword = 1'b0;
    short_signed  = 2'b00;
    dot_signed    = 2'b00;
    dot_a         = '0;
    dot_b         = '0;
    dot_c         = '0;
    ex_ready      = 1'b1;
    wait (rst_n === 1'b1);
    test_reset();
    test_mac();
    test_short();
    test_mulh();
    test_backpressure();
    test_dot();
    @(posedge clk);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* tb.f */
+incdir+hdl
hdl/mult_pkg.sv
hdl/mulh_sequencer.sv
hdl/short_mac.sv
hdl/dot_mult.sv
hdl/mult_unit.sv
verification/tb_clock_gen.sv
verification/mult_unit_tb.sv

/* Makefile */
# Verilator build and run of the multiply unit testbench

VERILATOR ?= verilator
TOP       ?= mult_unit_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o sim
	-./$(BUILD_DIR)/sim 2>&1 | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "STATUS: PASS" $(LOG); then \
		echo "simulation ended without a status, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
